// ==== hdl/sound_pkg.sv ====
// shared types, register map and ADPCM tables for the sound block; import where needed
package sound_pkg;

    localparam int NUM_VOICES = 2;                 // ADPCM voices sharing the ROM
    localparam int VOICE_W    = $clog2(NUM_VOICES); // width of a voice index

    typedef logic [18:0]        rom_addr_t;   // bit 18 is the bank bit
    typedef logic [17:0]        voice_addr_t; // byte address inside one bank
    typedef logic signed [11:0] pcm_t;        // decoded voice sample
    typedef logic signed [15:0] mix_t;        // mixer output
    typedef logic [7:0]         gain_t;       // unsigned 4.4 fixed point
    typedef logic [5:0]         step_idx_t;   // 0..48
    typedef logic [3:0]         reg_addr_t;   // CPU register address

    // CPU register map, multi-byte addresses go low byte first
    localparam reg_addr_t REG_CTRL     = 4'd0;  // bits 1:0 play, bits 5:4 stop
    localparam reg_addr_t REG_BANK     = 4'd1;  // bit 0 only
    localparam reg_addr_t REG_V0_START = 4'd2;  // 2..4
    localparam reg_addr_t REG_V0_END   = 4'd5;  // 5..7
    localparam reg_addr_t REG_V1_START = 4'd8;  // 8..10
    localparam reg_addr_t REG_V1_END   = 4'd11; // 11..13
    localparam reg_addr_t REG_GAIN0    = 4'd14;
    localparam reg_addr_t REG_GAIN1    = 4'd15;

    localparam int STEP_MAX = 48; // highest step index

    // standard 4-bit ADPCM step sizes
    localparam logic [10:0] STEP_TABLE [0:48] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,
        11'd25,   11'd28,   11'd31,   11'd34,   11'd37,
        11'd41,   11'd45,   11'd50,   11'd55,   11'd60,
        11'd66,   11'd73,   11'd80,   11'd88,   11'd97,
        11'd107,  11'd118,  11'd130,  11'd143,  11'd157,
        11'd173,  11'd190,  11'd209,  11'd230,  11'd253,
        11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,
        11'd724,  11'd796,  11'd876,  11'd963,  11'd1060,
        11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    // step index change per magnitude code, nibble bits 2:0
    localparam logic signed [4:0] INDEX_ADJ [0:7] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1,
        5'sd2,  5'sd4,  5'sd6,  5'sd8
    };

    // gain value that passes a voice through unchanged
    localparam gain_t GAIN_UNITY = 8'h10;

endpackage

// ==== hdl/pcm_rom_if.sv ====
// one request channel onto the sample ROM, voice side and arbiter side
interface pcm_rom_if;
    import sound_pkg::*;

    logic       req;  // held until ok
    rom_addr_t  addr; // stable while req is high
    logic [7:0] data; // valid with ok
    logic       ok;   // one-cycle completion

    // requester end
    modport voice (
        output req,
        output addr,
        input  data,
        input  ok
    );

    // arbiter end
    modport arbiter (
        input  req,
        input  addr,
        output data,
        output ok
    );

endinterface

// ==== hdl/adpcm_decoder.sv ====
// ADPCM nibble decoder with predictor and step index, one step per step_en
module adpcm_decoder (
    input  logic            CLK,
    input  logic            reset,
    input  logic            clear,   // back to predictor 0, index 0
    input  logic            step_en, // decode nibble this cycle
    input  logic [3:0]      nibble,
    output sound_pkg::pcm_t pcm      // predictor, updates a cycle after step_en
);
    import sound_pkg::*;

    step_idx_t         idx;
    logic [10:0]       step;
    logic [11:0]       diff;     // up to 1552 * 1.875
    logic signed [13:0] delta;
    logic signed [13:0] sum;
    logic signed [7:0] idx_sum;
    pcm_t              pred_next;
    step_idx_t         idx_next;

    always_comb begin
        step = STEP_TABLE[idx];
        diff = 12'(step >> 3);                       // base term, step/8
        if (nibble[2]) diff = diff + 12'(step);
        if (nibble[1]) diff = diff + 12'(step >> 1);
        if (nibble[0]) diff = diff + 12'(step >> 2);
        delta = nibble[3] ? -$signed({2'b00, diff}) : $signed({2'b00, diff}); // sign bit
        sum = $signed({{2{pcm[11]}}, pcm}) + delta;
        // clamp to 12-bit range
        if (sum > 14'sd2047)
            pred_next = 12'sd2047;
        else if (sum < -14'sd2048)
            pred_next = -12'sd2048;
        else
            pred_next = sum[11:0];
        idx_sum = $signed({2'b00, idx}) + INDEX_ADJ[nibble[2:0]];
        if (idx_sum < 8'sd0)
            idx_next = '0;
        else if (idx_sum > 8'(STEP_MAX))
            idx_next = step_idx_t'(STEP_MAX);
        else
            idx_next = idx_sum[5:0];
    end

    always_ff @(posedge CLK) begin
        if (reset || clear) begin    // clear wins over a step
            pcm <= '0;
            idx <= '0;
        end else if (step_en) begin
            pcm <= pred_next;
            idx <= idx_next;
        end
    end

endmodule

// ==== hdl/adpcm_voice.sv ====
// one ADPCM voice that fetches bytes over its ROM channel and decodes a nibble per sample_cen
module adpcm_voice (
    input  logic                   CLK,
    input  logic                   reset,
    input  logic                   play,       // load start, clear decoder, go busy
    input  logic                   stop,
    input  sound_pkg::voice_addr_t start_addr,
    input  sound_pkg::voice_addr_t end_addr,   // inclusive
    input  logic                   bank,
    input  logic                   sample_cen,
    pcm_rom_if.voice               rom,
    output logic                   busy,
    output sound_pkg::pcm_t        pcm
);
    import sound_pkg::*;

    voice_addr_t cur_addr;   // byte being fetched or decoded
    voice_addr_t end_q;
    logic        bank_q;
    logic [7:0]  byte_q;     // prefetch buffer
    logic        byte_valid;
    logic        phase;      // 0 high nibble next, 1 low nibble next
    logic        drop;       // data of the outstanding fetch is stale
    logic        take;       // decode one nibble now
    logic        dec_clear;
    logic [3:0]  nibble;

    assign rom.addr = {bank_q, cur_addr};
    assign take = sample_cen && busy && byte_valid && !play && !stop; // no byte means stall
    assign nibble = phase ? byte_q[3:0] : byte_q[7:4];
    // idle voice goes to 0 at the next sample after the end byte
    assign dec_clear = play || stop || (sample_cen && !busy);

    always_ff @(posedge CLK) begin
        if (reset) begin
            busy       <= 1'b0;
            rom.req    <= 1'b0;
            drop       <= 1'b0;
            byte_valid <= 1'b0;
            phase      <= 1'b0;
            cur_addr   <= '0;
            end_q      <= '0;
            bank_q     <= 1'b0;
        end else begin
            if (rom.ok) begin                  // fetch completes
                rom.req <= 1'b0;
                drop    <= 1'b0;
                if (!drop)
                    byte_valid <= 1'b1;
            end else if (busy && !byte_valid && !rom.req && !stop) begin
                rom.req <= 1'b1;               // next byte or refetch after a drop
            end

            if (take) begin
                if (phase) begin               // byte used up after its low nibble
                    phase      <= 1'b0;
                    byte_valid <= 1'b0;
                    if (cur_addr == end_q)
                        busy <= 1'b0;
                    else
                        cur_addr <= cur_addr + 18'd1;
                end else begin
                    phase <= 1'b1;
                end
            end

            if (stop) begin
                busy       <= 1'b0;
                byte_valid <= 1'b0;
                drop       <= rom.req && !rom.ok; // let the arbiter finish it
            end

            // play overrides stop in the same write
            if (play) begin
                cur_addr   <= start_addr;
                end_q      <= end_addr;
                bank_q     <= bank;
                phase      <= 1'b0;
                byte_valid <= 1'b0;
                busy       <= 1'b1;
                rom.req    <= 1'b1;                  // first request next cycle
                drop       <= rom.req && !rom.ok;
            end
        end
    end

    // loaded on every completion that is not dropped
    always_ff @(posedge CLK) begin
        if (rom.ok && !drop)
            byte_q <= rom.data;
    end

    adpcm_decoder u_dec (
        .CLK     ( CLK       ),
        .reset   ( reset     ),
        .clear   ( dec_clear ),
        .step_en ( take      ),
        .nibble  ( nibble    ),
        .pcm     ( pcm       )
    );

endmodule

// ==== hdl/pcm_rom_arbiter.sv ====
// round-robin arbiter giving the voices turns on the single sample ROM port
module pcm_rom_arbiter (
    input  logic                 CLK,
    input  logic                 reset,
    pcm_rom_if.arbiter           voice [sound_pkg::NUM_VOICES],
    output logic                 rom_req,
    output sound_pkg::rom_addr_t rom_addr,
    input  logic [7:0]           rom_data,
    input  logic                 rom_ok
);
    import sound_pkg::*;

    logic [NUM_VOICES-1:0] req;
    rom_addr_t             addr [NUM_VOICES];
    logic [VOICE_W-1:0]    owner;      // current or last granted voice
    logic [VOICE_W-1:0]    pick;
    logic                  pick_valid;

    // flatten the channel array, route completion only to the owner
    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_ch
        assign req[v]        = voice[v].req;
        assign addr[v]       = voice[v].addr;
        assign voice[v].ok   = rom_ok && rom_req && (owner == v);
        assign voice[v].data = (owner == v) ? rom_data : 8'h00;
    end

    // first requester after the last one served
    always_comb begin
        int cand;
        pick       = owner;
        pick_valid = 1'b0;
        for (int k = NUM_VOICES; k >= 1; k--) begin // smallest offset wins
            cand = int'(owner) + k;
            if (cand >= NUM_VOICES)
                cand = cand - NUM_VOICES;
            if (req[cand]) begin
                pick       = VOICE_W'(cand);
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            rom_req <= 1'b0;
            owner   <= VOICE_W'(NUM_VOICES - 1); // voice 0 goes first
        end else if (rom_req) begin
            if (rom_ok)
                rom_req <= 1'b0;                 // port free next cycle
        end else if (pick_valid) begin
            rom_req <= 1'b1;
            owner   <= pick;
        end
    end

    // address latched at grant, held through the transfer
    always_ff @(posedge CLK) begin
        if (!rom_req && pick_valid)
            rom_addr <= addr[pick];
    end

endmodule

// ==== hdl/sound_regs.sv ====
// CPU register file: voice addresses, bank, gains, play and stop pulses, busy readback
module sound_regs (
    input  logic                              CLK,
    input  logic                              reset,
    input  logic                              wr,
    input  sound_pkg::reg_addr_t              reg_addr,
    input  logic [7:0]                        wr_data,
    output logic [7:0]                        rd_data,
    input  logic [sound_pkg::NUM_VOICES-1:0]  busy,
    output logic [sound_pkg::NUM_VOICES-1:0]  play,
    output logic [sound_pkg::NUM_VOICES-1:0]  stop,
    output sound_pkg::voice_addr_t            start_addr [sound_pkg::NUM_VOICES],
    output sound_pkg::voice_addr_t            end_addr [sound_pkg::NUM_VOICES],
    output logic                              bank,
    output sound_pkg::gain_t                  gain [sound_pkg::NUM_VOICES]
);
    import sound_pkg::*;

    logic ctrl_wr;

    assign ctrl_wr = wr && (reg_addr == REG_CTRL);
    assign play    = ctrl_wr ? wr_data[NUM_VOICES-1:0] : '0;     // bits 1:0
    assign stop    = ctrl_wr ? wr_data[4 +: NUM_VOICES] : '0;    // bits 5:4
    assign rd_data = {{(8 - NUM_VOICES){1'b0}}, busy};           // status, no wait state

    always_ff @(posedge CLK) begin
        if (reset) begin
            bank <= 1'b0;
            for (int v = 0; v < NUM_VOICES; v++) begin
                start_addr[v] <= '0;
                end_addr[v]   <= '0;
                gain[v]       <= GAIN_UNITY;
            end
        end else if (wr) begin
            case (reg_addr)
                REG_BANK:           bank                <= wr_data[0];
                REG_V0_START:       start_addr[0][7:0]   <= wr_data;
                REG_V0_START + 4'd1: start_addr[0][15:8]  <= wr_data;
                REG_V0_START + 4'd2: start_addr[0][17:16] <= wr_data[1:0];
                REG_V0_END:         end_addr[0][7:0]     <= wr_data;
                REG_V0_END + 4'd1:   end_addr[0][15:8]    <= wr_data;
                REG_V0_END + 4'd2:   end_addr[0][17:16]   <= wr_data[1:0];
                REG_V1_START:       start_addr[1][7:0]   <= wr_data;
                REG_V1_START + 4'd1: start_addr[1][15:8]  <= wr_data;
                REG_V1_START + 4'd2: start_addr[1][17:16] <= wr_data[1:0];
                REG_V1_END:         end_addr[1][7:0]     <= wr_data;
                REG_V1_END + 4'd1:   end_addr[1][15:8]    <= wr_data;
                REG_V1_END + 4'd2:   end_addr[1][17:16]   <= wr_data[1:0];
                REG_GAIN0:          gain[0]             <= wr_data;
                REG_GAIN1:          gain[1]             <= wr_data;
                default: ;                               // REG_CTRL only pulses
            endcase
        end
    end

endmodule

// ==== hdl/sound_mixer.sv ====
// voice mixer: 4.4 gain per voice, sum, saturate to 16 bits, peak flag and sample strobe
module sound_mixer (
    input  logic             CLK,
    input  logic             reset,
    input  logic             sample_cen,
    input  sound_pkg::pcm_t  pcm [sound_pkg::NUM_VOICES],
    input  sound_pkg::gain_t gain [sound_pkg::NUM_VOICES],
    output sound_pkg::mix_t  mix,
    output logic             sample,   // marks a new mix value
    output logic             peak      // saturation on this sample
);
    import sound_pkg::*;

    logic               cen_d;         // voices settle one cycle after sample_cen
    logic signed [20:0] prod [NUM_VOICES];
    logic signed [21:0] acc;
    logic signed [17:0] scaled;
    logic               sat_hi;
    logic               sat_lo;
    mix_t               mix_next;

    always_comb begin
        acc = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            prod[v] = pcm[v] * $signed({1'b0, gain[v]}); // gain kept positive
            acc     = acc + prod[v];
        end
        scaled = acc[21:4];                              // drop 4 fraction bits, >>> 4
        sat_hi = scaled > 18'sd32767;
        sat_lo = scaled < -18'sd32768;
        if (sat_hi)
            mix_next = 16'sh7fff;
        else if (sat_lo)
            mix_next = 16'sh8000;
        else
            mix_next = scaled[15:0];
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            cen_d  <= 1'b0;
            sample <= 1'b0;
            mix    <= '0;
            peak   <= 1'b0;
        end else begin
            cen_d  <= sample_cen;
            sample <= cen_d;               // two cycles after sample_cen
            if (cen_d) begin               // mix and peak land with sample
                mix  <= mix_next;
                peak <= sat_hi || sat_lo;
            end
        end
    end

endmodule

// ==== hdl/sound_top.sv ====
// sound block top: CPU registers, two ADPCM voices, ROM arbiter and mixer on plain ports
module sound_top (
    input  logic                 CLK,
    input  logic                 reset,
    input  logic                 wr,
    input  sound_pkg::reg_addr_t reg_addr,
    input  logic [7:0]           wr_data,
    output logic [7:0]           rd_data,
    input  logic                 sample_cen,
    output logic                 rom_req,
    output sound_pkg::rom_addr_t rom_addr,
    input  logic [7:0]           rom_data,
    input  logic                 rom_ok,
    output sound_pkg::mix_t      mix,
    output logic                 sample,
    output logic                 peak
);
    import sound_pkg::*;

    logic [NUM_VOICES-1:0] busy;
    logic [NUM_VOICES-1:0] play;
    logic [NUM_VOICES-1:0] stop;
    voice_addr_t           start_addr [NUM_VOICES];
    voice_addr_t           end_addr [NUM_VOICES];
    logic                  bank;
    gain_t                 gain [NUM_VOICES];
    pcm_t                  pcm [NUM_VOICES];

    pcm_rom_if rom_ch [NUM_VOICES] ();    // one channel per voice

    sound_regs u_regs (
        .CLK        ( CLK        ),
        .reset      ( reset      ),
        .wr         ( wr         ),
        .reg_addr   ( reg_addr   ),
        .wr_data    ( wr_data    ),
        .rd_data    ( rd_data    ),
        .busy       ( busy       ),
        .play       ( play       ),
        .stop       ( stop       ),
        .start_addr ( start_addr ),
        .end_addr   ( end_addr   ),
        .bank       ( bank       ),
        .gain       ( gain       )
    );

    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        adpcm_voice u_voice (
            .CLK        ( CLK           ),
            .reset      ( reset         ),
            .play       ( play[v]       ),
            .stop       ( stop[v]       ),
            .start_addr ( start_addr[v] ),
            .end_addr   ( end_addr[v]   ),
            .bank       ( bank          ),
            .sample_cen ( sample_cen    ),
            .rom        ( rom_ch[v]     ),
            .busy       ( busy[v]       ),
            .pcm        ( pcm[v]        )
        );
    end

    pcm_rom_arbiter u_arb (
        .CLK      ( CLK      ),
        .reset    ( reset    ),
        .voice    ( rom_ch   ),
        .rom_req  ( rom_req  ),
        .rom_addr ( rom_addr ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   )
    );

    sound_mixer u_mix (
        .CLK        ( CLK        ),
        .reset      ( reset      ),
        .sample_cen ( sample_cen ),
        .pcm        ( pcm        ),
        .gain       ( gain       ),
        .mix        ( mix        ),
        .sample     ( sample     ),
        .peak       ( peak       )
    );

endmodule

// ==== dv/adpcm_ref.svh ====
// reference ADPCM step and mix rule for the sound testbench, included inside the bench module
`ifndef ADPCM_REF_SVH
`define ADPCM_REF_SVH

    // 4-bit ADPCM step sizes, index 0..48
    localparam int REF_STEPS [49] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66, 73,
        80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279, 307,
        337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963, 1060, 1166,
        1282, 1411, 1552
    };

    function automatic int clamp_int(input int x, input int lo, input int hi);
        if (x < lo)
            return lo;
        if (x > hi)
            return hi;
        return x;
    endfunction

    // one nibble in, next predictor and step index out
    function automatic void adpcm_step(input int pred, input int idx, input logic [3:0] nib,
                                       output int pred_n, output int idx_n);
        int step;
        int diff;
        step = REF_STEPS[idx];
        diff = step >> 3;              // always at least step/8
        if (nib[2])
            diff += step;
        if (nib[1])
            diff += step >> 1;
        if (nib[0])
            diff += step >> 2;
        if (nib[3])
            diff = -diff;              // sign bit
        pred_n = clamp_int(pred + diff, -2048, 2047);
        // codes 0..3 slow down by one, 4..7 speed up by 2, 4, 6, 8
        idx_n = clamp_int(idx + (nib[2] ? 2 * (int'(nib[1:0]) + 1) : -1), 0, 48);
    endfunction

    // gain products already summed, scale by 1/16 and clamp to 16 bits
    function automatic void mix_rule(input int acc, output int mixv, output logic sat);
        int scaled;
        scaled = acc >>> 4;
        sat    = scaled > 32767 || scaled < -32768; // peak when clamped
        mixv   = clamp_int(scaled, -32768, 32767);
    endfunction

`endif

// ==== dv/sound_tb.sv ====
// testbench for sound_top driving a command table and checking mix, ROM fetches and busy
module sound_tb;
    import sound_pkg::*;
    `include "adpcm_ref.svh"

    localparam int CLK_PERIOD = 4;
    localparam int CEN_PERIOD = 64;    // clocks between sample_cen pulses
    localparam int NUM_CMDS   = 5;

    typedef struct {
        logic [1:0][23:0] start;       // {voice 1, voice 0} written as three bytes each
        logic [1:0][23:0] last;        // inclusive end
        logic [1:0]       mask;        // voices to play
        logic [1:0][7:0]  gain;
        logic             bank;
        logic [1:0]       stop_mask;
        int               stop_at;     // samples before the stop write or 0
    } cmd_t;

    cmd_t cmds [NUM_CMDS] = '{
        '{{24'h0, 24'h00100}, {24'h0, 24'h0011f}, 2'b01, {8'h10, 8'h10}, 1'b0, 2'b00, 0},
        '{{24'h20000, 24'h0}, {24'h2000f, 24'h0}, 2'b10, {8'h18, 8'h10}, 1'b1, 2'b00, 0},
        '{{24'h03000, 24'h01000}, {24'h03017, 24'h0101f}, 2'b11, {8'h0c, 8'h10}, 1'b0, 2'b00, 0},
        '{{24'h06000, 24'h05000}, {24'h0603f, 24'h0503f}, 2'b11, {8'hff, 8'hff}, 1'b1, 2'b00, 0},
        '{{24'h09000, 24'h08000}, {24'h0903f, 24'h0807f}, 2'b11, {8'h20, 8'h20}, 1'b0, 2'b01, 10}
    };

    logic CLK = 1'b0;
    logic reset, wr, sample_cen, rom_req, rom_ok, sample, peak;
    reg_addr_t reg_addr;
    logic [7:0] wr_data, rd_data, rom_data;
    rom_addr_t rom_addr;
    mix_t mix;

    logic [7:0] rom_mem [0:(1 << 19) - 1];
    int ref_pred [NUM_VOICES];         // reference voice state
    int ref_idx [NUM_VOICES];
    voice_addr_t ref_addr [NUM_VOICES];
    voice_addr_t ref_last [NUM_VOICES];
    gain_t ref_gain [NUM_VOICES];
    logic [NUM_VOICES-1:0] ref_busy = '0;
    logic [NUM_VOICES-1:0] ref_phase;
    logic ref_bank;
    rom_addr_t fetch_next [NUM_VOICES]; // next byte each voice should fetch
    int fetch_left [NUM_VOICES];
    mix_t exp_mix_q [$];
    logic exp_peak_q [$];
    int cen_cnt = 0;
    int mix_errs = 0, peak_errs = 0, addr_errs = 0, busy_errs = 0, other_errs = 0;
    logic busy_due = 1'b0;             // check busy at the next negedge
    logic req_seen = 1'b0;

    sound_top UUT (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    task automatic check_mix(input mix_t act, input mix_t exp);
        if (act !== exp) begin
            mix_errs++;
            $display("ERROR: mix got %h expected %h at %0t", act, exp, $time);
        end
    endtask

    task automatic check_peak(input logic act, input logic exp);
        if (act !== exp) begin
            peak_errs++;
            $display("ERROR: peak got %h expected %h at %0t", act, exp, $time);
        end
    endtask

    task automatic check_rom_addr(input rom_addr_t act, input rom_addr_t exp);
        if (act !== exp) begin
            addr_errs++;
            $display("ERROR: rom_addr got %h expected %h at %0t", act, exp, $time);
        end
    endtask

    task automatic check_busy(input logic [NUM_VOICES-1:0] act, input logic [NUM_VOICES-1:0] exp);
        if (act !== exp) begin
            busy_errs++;
            $display("ERROR: busy got %h expected %h at %0t", act, exp, $time);
        end
    endtask

    // advance the reference voices by one sample and queue the expected mix
    task automatic ref_sample();
        int acc;
        int mixv;
        logic sat;
        logic [7:0] byte_v;
        logic [3:0] nib;
        acc = 0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (ref_busy[v]) begin
                byte_v = rom_mem[{ref_bank, ref_addr[v]}];
                nib = ref_phase[v] ? byte_v[3:0] : byte_v[7:4]; // high nibble first
                adpcm_step(ref_pred[v], ref_idx[v], nib, ref_pred[v], ref_idx[v]);
                if (ref_phase[v] && ref_addr[v] == ref_last[v])
                    ref_busy[v] = 1'b0;        // end byte done
                else if (ref_phase[v])
                    ref_addr[v]++;
                ref_phase[v] = ~ref_phase[v];
            end else begin
                ref_pred[v] = 0;               // idle voice is silent
            end
            acc += ref_pred[v] * int'(ref_gain[v]);
        end
        mix_rule(acc, mixv, sat);
        exp_mix_q.push_back(mix_t'(mixv));
        exp_peak_q.push_back(sat);
    endtask

    // match a new ROM request to the voice whose next byte it is
    task automatic note_fetch();
        int v;
        v = (fetch_left[0] > 0 && rom_addr == fetch_next[0]) ? 0 : 1;
        check_rom_addr(rom_addr, fetch_next[v]);
        if (fetch_left[v] <= 0) begin
            other_errs++;
            $display("voice %0d fetched a byte past its end address", v);
        end
        fetch_next[v]++;
        fetch_left[v]--;
    endtask

    // one clock that observes at the falling edge and then drives the next inputs
    task automatic tick();
        @(negedge CLK);
        wr = 1'b0;
        if (busy_due)
            check_busy(rd_data[NUM_VOICES-1:0], ref_busy);
        busy_due = 1'b0;
        if (sample && exp_mix_q.size() == 0) begin
            other_errs++;
            $display("sample strobe without a pending sample_cen");
        end else if (sample) begin
            check_mix(mix, exp_mix_q.pop_front());
            check_peak(peak, exp_peak_q.pop_front());
        end
        if (rom_req && !req_seen)
            note_fetch();
        req_seen = rom_req;
        sample_cen = (cen_cnt == CEN_PERIOD - 1);
        cen_cnt = sample_cen ? 0 : cen_cnt + 1;
        if (sample_cen) begin
            ref_sample();
            busy_due = 1'b1;
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input logic [7:0] data);
        tick();
        wr       = 1'b1;
        reg_addr = addr;
        wr_data  = data;
    endtask

    task automatic wait_sample();
        do
            tick();
        while (!sample_cen);
    endtask

    // random ROM contents, then a reply 1 to 8 clocks after each request
    initial begin : rom_model
        int wait_cycles;
        rom_ok   = 1'b0;
        rom_data = 8'h00;
        void'($urandom(32'hc3e08cac));
        foreach (rom_mem[a])
            rom_mem[a] = 8'($urandom);
        forever begin
            @(negedge CLK);
            rom_ok = 1'b0;
            if (rom_req === 1'b1) begin
                wait_cycles = 1 + ($urandom % 8);
                repeat (wait_cycles - 1) @(negedge CLK);
                rom_data = rom_mem[rom_addr];
                rom_ok   = 1'b1;
            end
        end
    end

    initial begin : watchdog
        int bytes;
        bytes = 0;
        foreach (cmds[r])
            for (int v = 0; v < NUM_VOICES; v++)
                if (cmds[r].mask[v])
                    bytes += int'(cmds[r].last[v] - cmds[r].start[v]) + 1;
        #(bytes * 2 * CEN_PERIOD * CLK_PERIOD + 40 * CEN_PERIOD * CLK_PERIOD);
        $display("timeout: the run did not finish within the time limit");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main
        reg_addr_t ra;
        int fails;
        reset      = 1'b1;
        wr         = 1'b0;
        reg_addr   = '0;
        wr_data    = 8'h00;
        sample_cen = 1'b0;
        repeat (16) @(negedge CLK);
        reset = 1'b0;
        if (rom_req !== 1'b0 || sample !== 1'b0) begin
            other_errs++;
            $display("rom_req or sample not low after reset");
        end
        check_peak(peak, 1'b0);
        check_busy(rd_data[NUM_VOICES-1:0], '0);

        foreach (cmds[r]) begin
            write_reg(REG_BANK, {7'b0, cmds[r].bank});
            for (int v = 0; v < NUM_VOICES; v++) begin
                for (int b = 0; b < 3; b++) begin
                    ra = reg_addr_t'(REG_V0_START + 6 * v + b);
                    write_reg(ra, cmds[r].start[v][8 * b +: 8]);
                    write_reg(ra + 4'd3, cmds[r].last[v][8 * b +: 8]); // end bytes follow
                end
                write_reg(reg_addr_t'(REG_GAIN0 + v), cmds[r].gain[v]);
                ref_gain[v] = cmds[r].gain[v];
            end
            wait_sample();                 // play early in a sample period so no voice stalls
            write_reg(REG_CTRL, {6'b0, cmds[r].mask});
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (cmds[r].mask[v]) begin
                    ref_busy[v]   = 1'b1;
                    ref_phase[v]  = 1'b0;
                    ref_pred[v]   = 0;
                    ref_idx[v]    = 0;
                    ref_addr[v]   = cmds[r].start[v][17:0];
                    ref_last[v]   = cmds[r].last[v][17:0];
                    fetch_next[v] = {cmds[r].bank, cmds[r].start[v][17:0]};
                    fetch_left[v] = int'(cmds[r].last[v] - cmds[r].start[v]) + 1;
                end
            end
            ref_bank = cmds[r].bank;
            busy_due = 1'b1;
            if (cmds[r].stop_at > 0) begin
                repeat (cmds[r].stop_at) wait_sample();
                write_reg(REG_CTRL, {2'b0, cmds[r].stop_mask, 4'b0});
                for (int v = 0; v < NUM_VOICES; v++) begin
                    if (cmds[r].stop_mask[v]) begin
                        ref_busy[v]   = 1'b0;
                        ref_pred[v]   = 0;
                        fetch_left[v] = 0;     // no fetch after the stop
                    end
                end
                busy_due = 1'b1;
            end
            do
                tick();
            while (rd_data[NUM_VOICES-1:0] != '0);
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (cmds[r].mask[v] && !cmds[r].stop_mask[v] && fetch_left[v] != 0) begin
                    other_errs++;
                    $display("voice %0d missed %0d byte fetches", v, fetch_left[v]);
                end
            end
        end

        wait_sample();                     // idle voices must mix to zero
        wait_sample();
        repeat (4) tick();
        if (exp_mix_q.size() != 0) begin
            other_errs++;
            $display("%0d sample strobes never arrived", exp_mix_q.size());
        end
        fails = mix_errs + peak_errs + addr_errs + busy_errs + other_errs;
        $display("errors: mix %0d, peak %0d, rom_addr %0d, busy %0d, other %0d",
                 mix_errs, peak_errs, addr_errs, busy_errs, other_errs);
        if (fails == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+dv
hdl/sound_pkg.sv
hdl/pcm_rom_if.sv
hdl/adpcm_decoder.sv
hdl/adpcm_voice.sv
hdl/pcm_rom_arbiter.sv
hdl/sound_regs.sv
hdl/sound_mixer.sv
hdl/sound_top.sv
dv/sound_tb.sv
